//--- Makefile
VERILATOR ?= verilator
TOP       := tb_mrelbp_ci
FLIST     := flist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG  := TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

# pass only if the simulation output holds the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/mrelbp_cfg.svh
`ifndef MRELBP_CFG_SVH
`define MRELBP_CFG_SVH

// ########################################
// frame geometry
// ########################################

// image size in pixels, fixed at build time
`define MRELBP_IMG_W 16
`define MRELBP_IMG_H 16

// ########################################
// window geometry
// ########################################

// radius 4 gives a 9x9 neighbourhood
`define MRELBP_R     4
`define MRELBP_WIN   9
`define MRELBP_NPIX  81

`endif

//--- common/mrelbp_pkg.sv
`default_nettype none

`include "mrelbp_cfg.svh"

package mrelbp_pkg;

    // one 8-bit unsigned pixel
    typedef logic [7:0] pix_t;

    // row-major window, entry NPIX/2 is the center
    typedef pix_t [`MRELBP_NPIX-1:0] window_t;

    // 81 * 255 = 20655 fits in 15 bits
    typedef logic [14:0] sum_t;

    // row or column index
    typedef logic [7:0] coord_t;

    // builder states
    typedef enum logic [1:0] {
        FILL,
        RUN,
        DONE
    } build_state_e;

endpackage

`default_nettype wire

//--- common/win_if.sv
`timescale 1ns/100ps
`default_nettype none

// completed window plus its center position, builder to CI unit
interface win_if;
    import mrelbp_pkg::*;

    logic    valid;
    window_t win;
    coord_t  row;
    coord_t  col;

    modport src (
        output valid,
        output win,
        output row,
        output col
    );

    modport dst (
        input valid,
        input win,
        input row,
        input col
    );

endinterface

`default_nettype wire

//--- dv/tb_mrelbp_ci.sv
`timescale 1ns/100ps
`default_nettype none

`include "mrelbp_cfg.svh"

module tb_mrelbp_ci;

    localparam int IMG_W       = `MRELBP_IMG_W;
    localparam int IMG_H       = `MRELBP_IMG_H;
    localparam int R           = `MRELBP_R;
    localparam int WIN         = `MRELBP_WIN;
    localparam int NPIX        = `MRELBP_NPIX;
    // seven frames in total and at most 4 cycles per pixel with gaps
    localparam int NUM_FRAMES  = 7;
    localparam int CYCLE_LIMIT = NUM_FRAMES * IMG_W * IMG_H * 4 + 1000;

    logic       clk;
    logic       rst;
    logic       pix_valid_i;
    logic       pix_sof_i;
    logic [7:0] pix_i;
    logic       ci_valid_o;
    logic       ci_o;
    logic [7:0] ci_row_o;
    logic [7:0] ci_col_o;

    // expected results as {ci, row, col}
    logic [16:0] exp_q [$];
    logic [16:0] exp_head;
    logic        head_ok;
    logic        pop_pending;
    logic        exp_strobe;

    logic [7:0]  img [IMG_H][IMG_W];
    logic [31:0] rng_state;
    int          err_count;
    int          err_mark;
    int          pass_count;
    int          fail_count;
    int          cycle_count = 0;

    mrelbp_ci_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .pix_valid_i (pix_valid_i),
        .pix_sof_i   (pix_sof_i),
        .pix_i       (pix_i),
        .ci_valid_o  (ci_valid_o),
        .ci_o        (ci_o),
        .ci_row_o    (ci_row_o),
        .ci_col_o    (ci_col_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run passed %0d cycles with results still missing", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ########################################
    // checks
    // ########################################

    latency_a : assert property (@(posedge clk) disable iff (rst)
        exp_strobe |-> ##3 ci_valid_o)
        else begin
            $display("latency error at %0t: no CI result 3 cycles after a completing pixel",
                     $time);
            err_count++;
        end

    spurious_a : assert property (@(posedge clk) disable iff (rst)
        ci_valid_o |-> head_ok)
        else begin
            $display("unexpected CI result at %0t with no window pending", $time);
            err_count++;
        end

    value_a : assert property (@(posedge clk) disable iff (rst)
        (ci_valid_o && head_ok) |-> ((ci_o == exp_head[16]) && (ci_row_o == exp_head[15:8])
                                     && (ci_col_o == exp_head[7:0])))
        else begin
            $display("mismatch at %0t: expected ci=%0b at (%0d,%0d), got ci=%0b at (%0d,%0d)",
                     $time, exp_head[16], exp_head[15:8], exp_head[7:0],
                     $sampled(ci_o), $sampled(ci_row_o), $sampled(ci_col_o));
            err_count++;
        end

    // ########################################
    // helpers
    // ########################################

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // center times 81 at least the window sum
    function automatic logic ref_ci(input int row, input int col);
        int sum;
        int center;
        sum = 0;
        for (int dr = -R; dr <= R; dr++) begin
            for (int dc = -R; dc <= R; dc++) begin
                sum += int'(img[row+dr][col+dc]);
            end
        end
        center = int'(img[row][col]);
        return (center * NPIX >= sum);
    endfunction

    // one clock of stimulus plus expected-queue bookkeeping
    task automatic drive_cycle(input logic valid, input logic sof, input logic [7:0] pix,
                               input logic cmpl, input logic [16:0] word);
        @(negedge clk);
        pix_valid_i = valid;
        pix_sof_i   = sof;
        pix_i       = pix;
        exp_strobe  = cmpl;
        if (cmpl) begin
            exp_q.push_back(word);
        end
        if (pop_pending && (exp_q.size() > 0)) begin
            void'(exp_q.pop_front());
        end
        // result on the output now is checked at the next rising edge
        pop_pending = ci_valid_o;
        head_ok     = (exp_q.size() > 0);
        if (head_ok) begin
            exp_head = exp_q[0];
        end
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, 1'b0, 8'h00, 1'b0, '0);
    endtask

    task automatic send_frame(input logic with_gaps);
        int          gap;
        logic        cmpl;
        logic [16:0] word;
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                if (with_gaps) begin
                    gap = int'(rand_word() % 32'd4);
                    repeat (gap) idle_cycle();
                end
                cmpl = (r >= WIN - 1) && (c >= WIN - 1);
                word = '0;
                if (cmpl) begin
                    word = {ref_ci(r - R, c - R), 8'(r - R), 8'(c - R)};
                end
                drive_cycle(1'b1, (r == 0) && (c == 0), img[r][c], cmpl, word);
            end
        end
    endtask

    task automatic drain_results();
        while ((exp_q.size() > 0) || pop_pending) begin
            idle_cycle();
        end
        repeat (4) idle_cycle();
    endtask

    task automatic fill_const(input logic [7:0] v);
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                img[r][c] = v;
            end
        end
    endtask

    task automatic fill_random();
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                img[r][c] = 8'(rand_word());
            end
        end
    endtask

    task automatic finish_test(input int num, input string name);
        if (err_count == err_mark) begin
            pass_count++;
            $display("test %0d %s: ok", num, name);
        end else begin
            fail_count++;
            $display("test %0d %s: failed with %0d errors", num, name, err_count - err_mark);
        end
        err_mark = err_count;
    endtask

    // ########################################
    // stimulus
    // ########################################

    initial begin
        rst         = 1'b1;
        pix_valid_i = 1'b0;
        pix_sof_i   = 1'b0;
        pix_i       = 8'h00;
        exp_strobe  = 1'b0;
        exp_head    = '0;
        head_ok     = 1'b0;
        pop_pending = 1'b0;
        rng_state   = 32'hdcba;
        err_count   = 0;
        err_mark    = 0;
        pass_count  = 0;
        fail_count  = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fill_const(8'd77);
        send_frame(1'b0);
        drain_results();
        finish_test(1, "flat frame");

        fill_const(8'd0);
        img[7][7] = 8'd255;
        send_frame(1'b0);
        drain_results();
        finish_test(2, "single bright pixel");

        // center (4,4) sits one below its mean and (4,11) equals its mean with remainder 50
        fill_const(8'd100);
        img[0][0]  = 8'd150;
        img[0][15] = 8'd150;
        img[4][4]  = 8'd99;
        img[4][11] = 8'd100;
        send_frame(1'b0);
        drain_results();
        finish_test(3, "remainder rule");

        fill_random();
        send_frame(1'b0);
        drain_results();
        finish_test(4, "random frame at full rate");

        fill_random();
        send_frame(1'b1);
        drain_results();
        finish_test(5, "random frame with gaps");

        fill_random();
        send_frame(1'b0);
        fill_random();
        send_frame(1'b0);
        drain_results();
        finish_test(6, "back-to-back frames");

        $display("tests passed: %0d  failed: %0d", pass_count, fail_count);
        if ((fail_count == 0) && (err_count == 0)) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+common
common/mrelbp_pkg.sv
common/win_if.sv
window/line_buffer.sv
window/window_builder.sv
verilog/ci_unit.sv
verilog/mrelbp_ci_top.sv
dv/tb_mrelbp_ci.sv

//--- verilog/ci_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "mrelbp_cfg.svh"

module ci_unit (
    input  logic                clk,
    input  logic                rst,
    win_if.dst                  win,
    output logic                ci_valid_o,
    output logic                ci_o,
    output mrelbp_pkg::coord_t  ci_row_o,
    output mrelbp_pkg::coord_t  ci_col_o
);
    import mrelbp_pkg::*;

    localparam int NPIX   = `MRELBP_NPIX;
    localparam int CENTER = NPIX / 2;
    localparam int LVLS   = $clog2(NPIX);
    localparam int LEAVES = 1 << LVLS;
    localparam int REM_W  = $clog2(NPIX);

    // ########################################
    // stage 1 balanced adder tree
    // ########################################

    // leaves past NPIX are tied to zero
    sum_t tree [LVLS+1][LEAVES];

    for (genvar gi = 0; gi < LEAVES; gi++) begin : g_leaf
        if (gi < NPIX) begin : g_pix
            assign tree[0][gi] = sum_t'(win.win[gi]);
        end else begin : g_pad
            assign tree[0][gi] = '0;
        end
    end

    for (genvar gl = 0; gl < LVLS; gl++) begin : g_lvl
        for (genvar gi = 0; gi < (LEAVES >> (gl + 1)); gi++) begin : g_node
            assign tree[gl+1][gi] = tree[gl][2*gi] + tree[gl][2*gi + 1];
        end
    end

    logic   s1_valid;
    sum_t   s1_sum;
    pix_t   s1_center;
    coord_t s1_row;
    coord_t s1_col;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= win.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (win.valid) begin
            s1_sum    <= tree[LVLS][0];
            s1_center <= win.win[CENTER];
            s1_row    <= win.row;
            s1_col    <= win.col;
        end
    end

    // ########################################
    // stage 2 mean and remainder compare
    // ########################################

    pix_t             mean_d;
    logic [REM_W-1:0] rem_d;
    logic             ci_d;

    assign mean_d = pix_t'(s1_sum / sum_t'(NPIX));
    assign rem_d  = REM_W'(s1_sum % sum_t'(NPIX));
    assign ci_d   = (s1_center > mean_d) || ((s1_center == mean_d) && (rem_d == '0));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ci_valid_o <= 1'b0;
        end else begin
            ci_valid_o <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            ci_o     <= ci_d;
            ci_row_o <= s1_row;
            ci_col_o <= s1_col;
        end
    end

    // same as center*81 >= sum
    ci_rule_a : assert property (@(posedge clk) disable iff (rst)
        ci_valid_o |-> (ci_o == (int'($past(s1_center)) * NPIX >= int'($past(s1_sum)))));

endmodule

`default_nettype wire

//--- verilog/mrelbp_ci_top.sv
`timescale 1ns/100ps
`default_nettype none

module mrelbp_ci_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       pix_valid_i,
    input  logic       pix_sof_i,
    input  logic [7:0] pix_i,
    output logic       ci_valid_o,
    output logic       ci_o,
    output logic [7:0] ci_row_o,
    output logic [7:0] ci_col_o
);

    // builder to CI unit
    win_if win_bus ();

    window_builder i_builder (
        .clk         (clk),
        .rst         (rst),
        .pix_valid_i (pix_valid_i),
        .pix_sof_i   (pix_sof_i),
        .pix_i       (pix_i),
        .win         (win_bus.src)
    );

    ci_unit i_ci (
        .clk        (clk),
        .rst        (rst),
        .win        (win_bus.dst),
        .ci_valid_o (ci_valid_o),
        .ci_o       (ci_o),
        .ci_row_o   (ci_row_o),
        .ci_col_o   (ci_col_o)
    );

endmodule

`default_nettype wire

//--- window/line_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "mrelbp_cfg.svh"

module line_buffer (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  shift_i,
    input  mrelbp_pkg::pix_t                      pix_i,
    output mrelbp_pkg::pix_t [`MRELBP_WIN-1:0]    col_o
);
    import mrelbp_pkg::*;

    localparam int DEPTH  = `MRELBP_IMG_W;
    localparam int NLINES = `MRELBP_WIN - 1;
    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    // line k delays its input by one image row
    pix_t             line_mem [NLINES][DEPTH];
    logic [PTR_W-1:0] wr_ptr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (shift_i) begin
            if (wr_ptr == LAST_PTR) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // all lines share one pointer, so the chain is a single W*8 delay
    always_ff @(posedge clk) begin
        if (shift_i) begin
            line_mem[0][wr_ptr] <= pix_i;
            for (int k = 1; k < NLINES; k++) begin
                line_mem[k][wr_ptr] <= line_mem[k-1][wr_ptr];
            end
        end
    end

    // ########################################
    // column output, oldest row at index 0
    // ########################################

    always_comb begin
        col_o[NLINES] = pix_i;
        for (int k = 0; k < NLINES; k++) begin
            col_o[NLINES-1-k] = line_mem[k][wr_ptr];
        end
    end

    ptr_range_a : assert property (@(posedge clk) disable iff (rst)
        wr_ptr < DEPTH);

endmodule

`default_nettype wire

//--- window/window_builder.sv
`timescale 1ns/100ps
`default_nettype none

`include "mrelbp_cfg.svh"

module window_builder (
    input  logic              clk,
    input  logic              rst,
    input  logic              pix_valid_i,
    input  logic              pix_sof_i,
    input  mrelbp_pkg::pix_t  pix_i,
    win_if.src                win
);
    import mrelbp_pkg::*;

    localparam int     WIN      = `MRELBP_WIN;
    localparam coord_t LAST_COL = coord_t'(`MRELBP_IMG_W - 1);
    localparam coord_t LAST_ROW = coord_t'(`MRELBP_IMG_H - 1);
    localparam coord_t EDGE     = coord_t'(WIN - 1);
    localparam coord_t RAD      = coord_t'(`MRELBP_R);

    build_state_e state_q;
    build_state_e state_d;
    build_state_e state_base;
    coord_t       row_q;
    coord_t       col_q;
    coord_t       cur_row;
    coord_t       cur_col;
    logic         accept;
    logic         complete;

    pix_t [WIN-1:0]          col_pix;
    pix_t [WIN-1:0][WIN-1:0] win_arr;

    line_buffer i_line_buffer (
        .clk     (clk),
        .rst     (rst),
        .shift_i (accept),
        .pix_i   (pix_i),
        .col_o   (col_pix)
    );

    // sof forces position 0,0 for the pixel that carries it
    assign cur_row  = pix_sof_i ? '0 : row_q;
    assign cur_col  = pix_sof_i ? '0 : col_q;
    assign accept   = pix_valid_i && (pix_sof_i || (state_q != DONE));
    assign complete = accept && (cur_row >= EDGE) && (cur_col >= EDGE);

    // ########################################
    // frame FSM
    // ########################################

    always_comb begin
        state_base = pix_sof_i ? FILL : state_q;
        state_d    = state_q;
        if (accept) begin
            state_d = state_base;
            if (cur_col == LAST_COL) begin
                if ((state_base == FILL) && (cur_row == EDGE - 1'b1)) begin
                    state_d = RUN;
                end else if ((state_base == RUN) && (cur_row == LAST_ROW)) begin
                    state_d = DONE;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= FILL;
            row_q     <= '0;
            col_q     <= '0;
            win.valid <= 1'b0;
        end else begin
            state_q   <= state_d;
            win.valid <= complete;
            if (accept) begin
                if (cur_col == LAST_COL) begin
                    col_q <= '0;
                    row_q <= cur_row + 1'b1;
                end else begin
                    col_q <= cur_col + 1'b1;
                    row_q <= cur_row;
                end
            end
        end
    end

    // ########################################
    // 9x9 shift array, newest column at index 8
    // ########################################

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int r = 0; r < WIN; r++) begin
                for (int c = 0; c < WIN - 1; c++) begin
                    win_arr[r][c] <= win_arr[r][c+1];
                end
                win_arr[r][WIN-1] <= col_pix[r];
            end
        end
        if (complete) begin
            win.row <= cur_row - RAD;
            win.col <= cur_col - RAD;
        end
    end

    // array holds the window until the next accepted pixel
    always_comb begin
        for (int r = 0; r < WIN; r++) begin
            for (int c = 0; c < WIN; c++) begin
                win.win[r*WIN + c] = win_arr[r][c];
            end
        end
    end

    no_win_in_fill_a : assert property (@(posedge clk) disable iff (rst)
        win.valid |-> (state_q != FILL));

endmodule

`default_nettype wire
